// ==== logic/icache_macros.svh ====
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// fetch address layout is | tag | index | offset |
`define ICACHE_ADDR_W   32
`define ICACHE_INDEX_W  6
`define ICACHE_OFFSET_W 6

// whatever is left above index and offset
`define ICACHE_TAG_W    (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// 64 sets per way
`define ICACHE_SETS     (1 << `ICACHE_INDEX_W)

// 64-byte lines, filled in one memory beat
`define ICACHE_LINE_W   (8 << `ICACHE_OFFSET_W)

// two instructions per fetch
`define ICACHE_FETCH_W  64

`endif

// ==== logic/icache_pkg.sv ====
`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL
    } cache_state_t;

    typedef logic [`ICACHE_ADDR_W-1:0]  addr_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [`ICACHE_LINE_W-1:0]  line_t;   // one full cache line
    typedef logic [`ICACHE_FETCH_W-1:0] fetch_t;  // one fetch slot

endpackage

`default_nettype wire

// ==== logic/icache_way.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_way (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     i_rd_en,
    input  wire icache_pkg::index_t i_rd_index,
    input  wire icache_pkg::tag_t   i_req_tag,
    input  wire                     i_wr_en,
    input  wire icache_pkg::index_t i_wr_index,
    input  wire icache_pkg::tag_t   i_wr_tag,
    input  wire icache_pkg::line_t  i_wr_line,
    output logic                    o_hit,
    output icache_pkg::line_t       o_line
);
    import icache_pkg::*;

    logic [`ICACHE_SETS-1:0] valid_q;
    tag_t                    tag_mem  [`ICACHE_SETS];
    line_t                   line_mem [`ICACHE_SETS];

    index_t rd_index_q;  // set held in the read registers
    index_t look_index;
    logic   wr_same;
    logic   valid_rd_q;
    tag_t   tag_rd_q;
    line_t  line_rd_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (i_wr_en) begin
            valid_q[i_wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_mem[i_wr_index]  <= i_wr_tag;
            line_mem[i_wr_index] <= i_wr_line;
        end
    end

    // set being read now, else the one already held
    assign look_index = i_rd_en ? i_rd_index : rd_index_q;
    assign wr_same    = i_wr_en && (i_wr_index == look_index);

    // a refill into the looked-up set wins over the stale array word
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            rd_index_q <= i_rd_index;
        end
        if (wr_same) begin
            tag_rd_q  <= i_wr_tag;
            line_rd_q <= i_wr_line;
        end else if (i_rd_en) begin
            tag_rd_q  <= tag_mem[i_rd_index];
            line_rd_q <= line_mem[i_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_rd_q <= 1'b0;
        end else if (wr_same) begin
            valid_rd_q <= 1'b1;
        end else if (i_rd_en) begin
            valid_rd_q <= valid_q[i_rd_index];
        end
    end

    assign o_hit  = valid_rd_q && (tag_rd_q == i_req_tag);  // tag from request buffer
    assign o_line = line_rd_q;

endmodule

`default_nettype wire

// ==== logic/icache_lru.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_lru (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire icache_pkg::index_t i_index,
    input  wire                     i_touch,
    input  wire                     i_touch_way,
    output logic                    o_victim_way
);
    import icache_pkg::*;

    // one bit per set, the way used last
    logic [`ICACHE_SETS-1:0] mru_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mru_q <= '0;
        end else if (i_touch) begin
            mru_q[i_index] <= i_touch_way;  // hit way or refilled way
        end
    end

    // with two ways the victim is simply the other one
    assign o_victim_way = ~mru_q[i_index];

endmodule

`default_nettype wire

// ==== logic/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  wire  clk,
    input  wire  rstn,
    input  wire  i_rvalid,
    input  wire  i_flush,
    input  wire  i_hit,
    input  wire  i_adef,
    input  wire  i_mem_rready,
    output logic o_req_ready,
    output logic o_capture,
    output logic o_resp_valid,
    output logic o_mem_rvalid,
    output logic o_refill,
    output logic o_from_ret,
    output logic o_lru_touch,
    output logic o_idle
);
    import icache_pkg::*;

    cache_state_t state_q;
    cache_state_t state_d;
    logic         flush_pend_q;  // response of the buffered request is dropped
    logic         respond;       // this cycle finishes the buffered request

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // a new capture starts clean, even when a flush comes in the same cycle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            flush_pend_q <= 1'b0;
        end else if (o_capture) begin
            flush_pend_q <= 1'b0;
        end else if (i_flush) begin
            flush_pend_q <= 1'b1;
        end
    end

    always_comb begin
        state_d      = state_q;
        o_req_ready  = 1'b0;
        respond      = 1'b0;
        o_mem_rvalid = 1'b0;
        o_refill     = 1'b0;
        o_from_ret   = 1'b0;
        o_lru_touch  = 1'b0;

        case (state_q)
            IDLE: begin
                o_req_ready = 1'b1;
                if (i_rvalid) begin
                    state_d = LOOKUP;
                end
            end

            LOOKUP: begin
                // misaligned fetch answers right away, no memory read
                if (i_adef || i_hit) begin
                    respond     = 1'b1;
                    o_req_ready = 1'b1;
                    o_lru_touch = !i_adef;
                    state_d     = i_rvalid ? LOOKUP : IDLE;
                end else begin
                    state_d = MISS;
                end
            end

            MISS: begin
                o_mem_rvalid = 1'b1;  // held until memory takes it
                if (i_mem_rready) begin
                    state_d = REFILL;
                end
            end

            REFILL: begin
                o_refill    = 1'b1;
                o_from_ret  = 1'b1;  // data comes from the return buffer
                o_lru_touch = 1'b1;
                respond     = 1'b1;
                o_req_ready = 1'b1;
                state_d     = i_rvalid ? LOOKUP : IDLE;
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign o_capture = o_req_ready && i_rvalid;

    // a flush in the response cycle itself also kills it
    assign o_resp_valid = respond && !flush_pend_q && !i_flush;

    assign o_idle = (state_q == IDLE);

endmodule

`default_nettype wire

// ==== logic/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     i_rvalid,
    input  wire icache_pkg::addr_t  i_raddr,
    input  wire                     i_flush,
    output logic                    o_req_ready,
    output logic                    o_resp_valid,
    output icache_pkg::fetch_t      o_rdata,
    output icache_pkg::addr_t       o_pc,
    output logic                    o_exc_adef,
    output logic                    o_mem_rvalid,
    output icache_pkg::addr_t       o_mem_raddr,
    input  wire                     i_mem_rready,
    input  wire icache_pkg::line_t  i_mem_rdata,
    output logic                    o_idle
);
    import icache_pkg::*;

    addr_t  req_q;  // accepted fetch address
    line_t  ret_q;  // line of the last memory transfer
    logic   capture;
    logic   refill;
    logic   from_ret;
    logic   lru_touch;
    logic   adef;
    logic   hit0;
    logic   hit1;
    logic   hit;
    line_t  line0;
    line_t  line1;
    line_t  line_sel;
    logic   victim_way;
    index_t rd_index;
    index_t req_index;
    tag_t   req_tag;

    always_ff @(posedge clk) begin
        if (capture) begin
            req_q <= i_raddr;
        end
    end

    always_ff @(posedge clk) begin
        if (o_mem_rvalid && i_mem_rready) begin
            ret_q <= i_mem_rdata;
        end
    end

    assign rd_index  = i_raddr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];  // arrays read at accept
    assign req_index = req_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign req_tag   = req_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

    assign adef = |req_q[1:0];
    assign hit  = hit0 | hit1;

    // pick the line, then the 64-bit slot by address bits 5:3
    assign line_sel = from_ret ? ret_q : (hit1 ? line1 : line0);
    assign o_rdata  = line_sel[req_q[`ICACHE_OFFSET_W-1:3] * `ICACHE_FETCH_W +: `ICACHE_FETCH_W];

    assign o_pc        = req_q;
    assign o_exc_adef  = adef;
    assign o_mem_raddr = {req_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .i_rvalid     (i_rvalid),
        .i_flush      (i_flush),
        .i_hit        (hit),
        .i_adef       (adef),
        .i_mem_rready (i_mem_rready),
        .o_req_ready  (o_req_ready),
        .o_capture    (capture),
        .o_resp_valid (o_resp_valid),
        .o_mem_rvalid (o_mem_rvalid),
        .o_refill     (refill),
        .o_from_ret   (from_ret),
        .o_lru_touch  (lru_touch),
        .o_idle       (o_idle)
    );

    icache_way u_way0 (
        .clk        (clk),
        .rstn       (rstn),
        .i_rd_en    (capture),
        .i_rd_index (rd_index),
        .i_req_tag  (req_tag),
        .i_wr_en    (refill && !victim_way),
        .i_wr_index (req_index),
        .i_wr_tag   (req_tag),
        .i_wr_line  (ret_q),
        .o_hit      (hit0),
        .o_line     (line0)
    );

    icache_way u_way1 (
        .clk        (clk),
        .rstn       (rstn),
        .i_rd_en    (capture),
        .i_rd_index (rd_index),
        .i_req_tag  (req_tag),
        .i_wr_en    (refill && victim_way),
        .i_wr_index (req_index),
        .i_wr_tag   (req_tag),
        .i_wr_line  (ret_q),
        .o_hit      (hit1),
        .o_line     (line1)
    );

    // refill marks the victim as used, a hit marks the hitting way
    icache_lru u_lru (
        .clk          (clk),
        .rstn         (rstn),
        .i_index      (req_index),
        .i_touch      (lru_touch),
        .i_touch_way  (from_ret ? victim_way : hit1),
        .o_victim_way (victim_way)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module tb_icache;
    import icache_pkg::*;

    localparam int WAIT_LIMIT = 200;  // cycles allowed per wait

    typedef struct packed {
        addr_t       pc;
        fetch_t      data;
        logic        miss;
        logic        adef;
        logic [31:0] cyc;  // cycle seen just before the accepting edge
    } expect_t;

    logic   clk = 1'b0;
    logic   rstn;
    logic   i_rvalid;
    addr_t  i_raddr;
    logic   i_flush;
    logic   o_req_ready;
    logic   o_resp_valid;
    fetch_t o_rdata;
    addr_t  o_pc;
    logic   o_exc_adef;
    logic   o_mem_rvalid;
    addr_t  o_mem_raddr;
    logic   i_mem_rready;
    line_t  i_mem_rdata;
    logic   o_idle;

    int cyc = 0;
    int xfer_cyc = 0;  // cycle of the last completed memory beat
    int trace_errors = 0;
    int data_errors = 0;
    int protocol_errors = 0;
    int timeouts = 0;

    addr_t   tr_addr[$];
    logic    tr_flush[$];
    fetch_t  tr_data[$];
    logic    tr_miss[$];
    logic    tr_adef[$];
    expect_t resp_q[$];  // responses still owed, oldest first
    addr_t   mem_q[$];   // line reads still owed

    // reference cache, most recently used bit per set
    logic mdl_valid [2][`ICACHE_SETS];
    tag_t mdl_tag   [2][`ICACHE_SETS];
    logic mdl_mru   [`ICACHE_SETS];

    icache u_dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // slot rule of the memory, upper half A+8k and lower half its complement
    function automatic fetch_t slot_word(input addr_t addr);
        addr_t base;
        base = {addr[31:3], 3'b000};
        return {base, ~base};
    endfunction

    function automatic line_t line_for(input addr_t line_addr);
        line_t line;
        int    k;
        line = '0;
        for (k = 0; k < 8; k++) begin
            line[k*64 +: 64] = slot_word(line_addr + 32'(8 * k));
        end
        return line;
    endfunction

    task automatic model_access(input addr_t addr, output logic miss);
        index_t idx;
        tag_t   tag;
        logic   victim;
        idx  = addr[11:6];
        tag  = addr[31:12];
        miss = 1'b0;
        if (mdl_valid[0][idx] && mdl_tag[0][idx] == tag) begin
            mdl_mru[idx] = 1'b0;
        end else if (mdl_valid[1][idx] && mdl_tag[1][idx] == tag) begin
            mdl_mru[idx] = 1'b1;
        end else begin
            miss   = 1'b1;
            victim = !mdl_mru[idx];  // the way not used last
            mdl_valid[victim][idx] = 1'b1;
            mdl_tag[victim][idx]   = tag;
            mdl_mru[idx]           = victim;
        end
    endtask

    task automatic load_trace();
        int     fd;
        int     n;
        int     fl;
        int     ms;
        int     ad;
        string  line;
        addr_t  a;
        fetch_t d;
        logic   pred_miss;
        for (n = 0; n < `ICACHE_SETS; n++) begin
            mdl_valid[0][n] = 1'b0;
            mdl_valid[1][n] = 1'b0;
            mdl_mru[n]      = 1'b0;
        end
        fd = $fopen("testbench/icache_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file testbench/icache_trace.txt");
            trace_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%h %d %h %d %d", a, fl, d, ms, ad);
            if (n != 5) continue;
            pred_miss = 1'b0;
            if (ad == 0) model_access(a, pred_miss);
            assert ((ad != 0) == (a[1:0] != 2'b00)) else begin
                $display("[ERROR] %0t: trace adef column wrong for %h", $time, a);
                trace_errors++;
            end
            assert (pred_miss == (ms != 0)) else begin
                $display("[ERROR] %0t: trace miss column disagrees with model at %h", $time, a);
                trace_errors++;
            end
            assert (ad != 0 || d == slot_word(a)) else begin
                $display("[ERROR] %0t: trace data for %h breaks the line rule", $time, a);
                trace_errors++;
            end
            tr_addr.push_back(a);
            tr_flush.push_back(fl != 0);
            tr_data.push_back(d);
            tr_miss.push_back(ms != 0);
            tr_adef.push_back(ad != 0);
        end
        $fclose(fd);
        if (tr_addr.size() == 0) begin
            $display("the trace file holds no fetches");
            trace_errors++;
        end
    endtask

    task automatic drive_trace();
        int      i;
        int      waited;
        expect_t e;
        @(posedge clk);
        for (i = 0; i < tr_addr.size(); i++) begin
            i_rvalid <= 1'b1;
            i_raddr  <= tr_addr[i];
            waited = 0;
            @(negedge clk);
            while (!o_req_ready && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!o_req_ready) begin
                $display("timeout: fetch %0d at %h was never accepted", i, tr_addr[i]);
                timeouts++;
                return;
            end
            // behind a hit or misaligned fetch the next one goes in at once
            if (i > 0 && !tr_miss[i-1]) begin
                assert (waited == 0) else begin
                    $display("[ERROR] %0t: fetch %h stalled %0d cycles behind a hit",
                             $time, tr_addr[i], waited);
                    protocol_errors++;
                end
            end
            if (tr_miss[i]) mem_q.push_back({tr_addr[i][31:6], 6'b000000});
            if (!tr_flush[i]) begin
                e.pc   = tr_addr[i];
                e.data = tr_data[i];
                e.miss = tr_miss[i];
                e.adef = tr_adef[i];
                e.cyc  = cyc;
                resp_q.push_back(e);
            end
            @(posedge clk);  // accepting edge
            if (tr_flush[i]) begin
                i_rvalid <= 1'b0;
                i_flush  <= 1'b1;  // lands in the lookup cycle
                @(posedge clk);
                i_flush  <= 1'b0;
            end
        end
        i_rvalid <= 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while ((resp_q.size() != 0 || mem_q.size() != 0 || !o_idle) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (resp_q.size() != 0 || mem_q.size() != 0 || !o_idle) begin
            $display("timeout: %0d responses and %0d memory reads never arrived",
                     resp_q.size(), mem_q.size());
            timeouts++;
        end
    endtask

    always @(negedge clk) begin : response_monitor
        expect_t e;
        if (rstn && o_resp_valid) begin
            assert (resp_q.size() != 0) else begin
                $display("[ERROR] %0t: response for %h with no fetch owed", $time, o_pc);
                protocol_errors++;
            end
            if (resp_q.size() != 0) begin
                e = resp_q.pop_front();
                assert (o_pc == e.pc) else begin
                    $display("[ERROR] %0t: pc %h, expected %h", $time, o_pc, e.pc);
                    protocol_errors++;
                end
                assert (o_exc_adef == e.adef) else begin
                    $display("[ERROR] %0t: adef %b for %h", $time, o_exc_adef, e.pc);
                    data_errors++;
                end
                if (!e.adef) begin
                    assert (o_rdata == e.data) else begin
                        $display("[ERROR] %0t: data %h for %h, expected %h",
                                 $time, o_rdata, e.pc, e.data);
                        data_errors++;
                    end
                end
                if (e.miss) begin
                    assert (cyc == xfer_cyc + 1) else begin
                        $display("[ERROR] %0t: miss on %h not answered right after refill",
                                 $time, e.pc);
                        protocol_errors++;
                    end
                end else begin
                    assert (cyc == int'(e.cyc) + 1) else begin
                        $display("[ERROR] %0t: hit on %h took %0d cycles",
                                 $time, e.pc, cyc - int'(e.cyc));
                        protocol_errors++;
                    end
                end
            end
        end
    end

    // memory with a random stall of 0 to 3 cycles per read
    initial begin : memory_model
        int    stall;
        int    k;
        addr_t raddr;
        addr_t want;
        forever begin
            @(negedge clk);
            if (rstn && o_mem_rvalid) begin
                raddr = o_mem_raddr;
                assert (mem_q.size() != 0) else begin
                    $display("[ERROR] %0t: memory read of %h with no miss owed", $time, raddr);
                    protocol_errors++;
                end
                if (mem_q.size() != 0) begin
                    want = mem_q.pop_front();
                    assert (raddr == want) else begin
                        $display("[ERROR] %0t: memory read of %h, expected %h", $time, raddr, want);
                        protocol_errors++;
                    end
                end
                stall = $urandom % 4;
                for (k = 0; k < stall; k++) begin
                    @(posedge clk);
                end
                @(posedge clk);
                i_mem_rready <= 1'b1;
                i_mem_rdata  <= line_for(raddr);
                @(negedge clk);
                assert (o_mem_rvalid && o_mem_raddr == raddr) else begin
                    $display("[ERROR] %0t: memory request dropped or moved while stalled", $time);
                    protocol_errors++;
                end
                xfer_cyc = cyc;
                @(posedge clk);
                i_mem_rready <= 1'b0;
            end
        end
    end

    initial begin : main
        rstn         = 1'b0;
        i_rvalid     = 1'b0;
        i_raddr      = '0;
        i_flush      = 1'b0;
        i_mem_rready = 1'b0;
        i_mem_rdata  = '0;
        void'($urandom(32'h6b00_9000));
        load_trace();
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        assert (o_req_ready && o_idle && !o_resp_valid && !o_mem_rvalid) else begin
            $display("[ERROR] %0t: outputs not in their reset state", $time);
            protocol_errors++;
        end
        if (trace_errors == 0) drive_trace();
        if (trace_errors == 0 && timeouts == 0) drain();
        $display("errors: trace %0d, data %0d, protocol %0d, timeouts %0d",
                 trace_errors, data_errors, protocol_errors, timeouts);
        if (trace_errors + data_errors + protocol_errors + timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== icache.f ====
+incdir+logic
logic/icache_pkg.sv
logic/icache_way.sv
logic/icache_lru.sv
logic/icache_ctrl.sv
logic/icache.sv
testbench/tb_icache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the icache testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1

rm -f sim.log \
    && verilator --binary --timing --assert -f icache.f --top-module tb_icache -o tb_icache \
    && ./obj_dir/tb_icache > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "ALL CHECKS PASSED" sim.log \
    && echo "result: pass" \
    || { echo "result: fail"; exit 1; }

// ==== testbench/icache_trace.txt ====
# address  flush  expected data  miss  adef   (all hex, one fetch per line)
# data is don't care on adef rows, flushed rows expect no response
00001000 0 00001000ffffefff 1 0
00001048 0 00001048ffffefb7 1 0
00002090 0 00002090ffffdf6f 1 0
00001008 0 00001008ffffeff7 0 0
00001010 0 00001010ffffefef 0 0
00001018 0 00001018ffffefe7 0 0
00001038 0 00001038ffffefc7 0 0
00001040 0 00001040ffffefbf 0 0
00002098 0 00002098ffffdf67 0 0
000030c0 0 000030c0ffffcf3f 1 0
000040c8 0 000040c8ffffbf37 1 0
000030d0 0 000030d0ffffcf2f 0 0
000050f8 0 000050f8ffffaf07 1 0
000030c0 0 000030c0ffffcf3f 0 0
000040c0 0 000040c0ffffbf3f 1 0
000050c0 0 000050c0ffffaf3f 1 0
000040d8 0 000040d8ffffbf27 0 0
00001002 0 0000000000000000 0 1
00007001 0 0000000000000000 0 1
00001020 0 00001020ffffefdf 0 0
00008100 1 00008100ffff7eff 1 0
00008108 0 00008108ffff7ef7 0 0
00009140 1 00009140ffff6ebf 1 0
00009140 0 00009140ffff6ebf 0 0
00008110 0 00008110ffff7eef 0 0
00008118 0 00008118ffff7ee7 0 0
00009148 0 00009148ffff6eb7 0 0
000030c8 0 000030c8ffffcf37 1 0
000050c0 0 000050c0ffffaf3f 1 0
000030c0 0 000030c0ffffcf3f 0 0
